/* sms_glue_config.svh */
`ifndef SMS_GLUE_CONFIG_SVH
`define SMS_GLUE_CONFIG_SVH

// CPU clock enable divider
`define SMS_CLK_DIV       7   // cpuClock cycles per CPU clock
`define SMS_CLK_EN_BIT    2   // Divider count bit used as the enable

// Widths
`define SMS_SLOT_W        8   // Mapper slot register width
`define SMS_BANK_AW       14  // Offset inside one 16 kB bank
`define SMS_VRAM_AW       14
`define SMS_BTN_W         7

// Video chip register file
`define SMS_VDP_REGS      11

// Reset values
`define SMS_MEM_CTRL_RST  8'hF7  // Bit 3 low selects the BIOS
`define SMS_SLOT0_RST     8'd0
`define SMS_SLOT1_RST     8'd1
`define SMS_SLOT2_RST     8'd2

`endif

/* sms_bus_pkg.sv */
`include "sms_glue_config.svh"

package sms_bus_pkg;

  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0]  cpu_byte_t;

  // Slot number followed by the bank offset
  typedef logic [`SMS_SLOT_W+`SMS_BANK_AW-1:0] rom_addr_t;

  // Decoded I/O port, one at a time
  typedef enum logic [3:0] {
    IO_NONE,
    IO_VDP_DATA,
    IO_VDP_CTRL,
    IO_PSG,
    IO_JOY0,
    IO_JOY1,
    IO_MEM_CTRL,
    IO_VCOUNT,
    IO_HCOUNT
  } io_sel_t;

  // Address bits 15:14
  typedef enum logic [1:0] {
    REGION_SLOT0,
    REGION_SLOT1,
    REGION_SLOT2,
    REGION_RAM
  } mem_region_t;

endpackage

/* sms_vdp_pkg.sv */
package sms_vdp_pkg;

  typedef logic [3:0] vdp_reg_idx_t;

  typedef enum logic [2:0] {
    MODE_0,
    MODE_1,
    MODE_2,
    MODE_3,
    MODE_4
  } vdp_mode_t;

  // Top two bits of the second control byte
  typedef enum logic [1:0] {
    CODE_VRAM_RD,
    CODE_VRAM_WR,
    CODE_REG_WR,
    CODE_CRAM_WR
  } vdp_code_t;

  typedef struct packed {
    vdp_code_t    code;
    logic [5:0]   addr_hi;  // VRAM address bits 13:8
  } vdp_addr_byte_t;

  typedef struct packed {
    vdp_code_t    code;
    logic [1:0]   spare;
    vdp_reg_idx_t idx;
  } vdp_reg_byte_t;

  // Same byte, seen as an address or as a register write
  typedef union packed {
    vdp_addr_byte_t addr;
    vdp_reg_byte_t  reg_wr;
  } vdp_ctrl_byte_u;

endpackage

/* sms_cpu_bus_if.sv */
interface sms_cpu_bus_if;

  sms_bus_pkg::cpu_addr_t address;
  sms_bus_pkg::cpu_byte_t data_out;
  logic                   cpu_edge;     // First cycle of the CPU clock enable
  sms_bus_pkg::io_sel_t   io_rd_sel;
  sms_bus_pkg::io_sel_t   io_wr_sel;
  logic                   mem_wr;
  logic                   mem_rd_cart;  // Memory read below C000
  logic                   mapper_wr;    // Write to FFFC-FFFF
  logic [1:0]             mapper_idx;

  modport ctrl (
    output address, data_out, cpu_edge, io_rd_sel, io_wr_sel,
    output mem_wr, mem_rd_cart, mapper_wr, mapper_idx
  );

  modport periph (
    input address, data_out, cpu_edge, io_rd_sel, io_wr_sel,
    input mem_wr, mem_rd_cart, mapper_wr, mapper_idx
  );

endinterface

/* sms_bus_ctrl.sv */
`include "sms_glue_config.svh"

module sms_bus_ctrl (
  input  logic                   cpuClock,
  input  logic                   n_hard_reset,
  input  sms_bus_pkg::cpu_addr_t i_cpu_address,
  input  sms_bus_pkg::cpu_byte_t i_cpu_data_out,
  input  logic                   i_n_rd,
  input  logic                   i_n_wr,
  input  logic                   i_n_mreq,
  input  logic                   i_n_iorq,
  output logic                   o_cpu_clk_en,
  output logic                   o_ram_we,
  sms_cpu_bus_if.ctrl            bus
);

  localparam int CNT_W = $clog2(`SMS_CLK_DIV);

  logic [CNT_W-1:0]         clk_cnt;
  logic                     clk_en_q;
  logic                     io_rd, io_wr, mem_rd;
  sms_bus_pkg::mem_region_t region;
  sms_bus_pkg::io_sel_t     port_rd, port_wr;

  // ======================================================================
  // CPU clock enable
  // ======================================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      clk_cnt  <= '0;
      clk_en_q <= 1'b0;
    end else begin
      clk_en_q <= o_cpu_clk_en;
      if (clk_cnt == CNT_W'(`SMS_CLK_DIV - 1))
        clk_cnt <= '0;
      else
        clk_cnt <= clk_cnt + 1'b1;
    end
  end

  assign o_cpu_clk_en = clk_cnt[`SMS_CLK_EN_BIT];
  assign bus.cpu_edge = o_cpu_clk_en && !clk_en_q;  // Rising edge only

  // ======================================================================
  // Strobes and decode
  // ======================================================================
  assign io_rd      = !(i_n_rd | i_n_iorq);
  assign io_wr      = !(i_n_wr | i_n_iorq);
  assign mem_rd     = !(i_n_rd | i_n_mreq);
  assign bus.mem_wr = !(i_n_wr | i_n_mreq);

  // Ports decode on A7:A6 and A0 only
  always_comb begin
    port_rd = sms_bus_pkg::IO_NONE;
    port_wr = sms_bus_pkg::IO_NONE;
    case ({i_cpu_address[7:6], i_cpu_address[0]})
      3'b000: port_wr = sms_bus_pkg::IO_MEM_CTRL;
      3'b010: port_rd = sms_bus_pkg::IO_VCOUNT;
      3'b011: begin
        port_rd = sms_bus_pkg::IO_HCOUNT;
        port_wr = sms_bus_pkg::IO_PSG;
      end
      3'b100: begin
        port_rd = sms_bus_pkg::IO_VDP_DATA;
        port_wr = sms_bus_pkg::IO_VDP_DATA;
      end
      3'b101: begin
        port_rd = sms_bus_pkg::IO_VDP_CTRL;
        port_wr = sms_bus_pkg::IO_VDP_CTRL;
      end
      3'b110: port_rd = sms_bus_pkg::IO_JOY0;
      3'b111: port_rd = sms_bus_pkg::IO_JOY1;
      default: ;  // Joypad control port not kept
    endcase
  end

  assign bus.io_rd_sel = io_rd ? port_rd : sms_bus_pkg::IO_NONE;
  assign bus.io_wr_sel = io_wr ? port_wr : sms_bus_pkg::IO_NONE;

  assign region          = sms_bus_pkg::mem_region_t'(i_cpu_address[15:14]);
  assign bus.mem_rd_cart = mem_rd && region != sms_bus_pkg::REGION_RAM;
  assign o_ram_we        = bus.mem_wr && region == sms_bus_pkg::REGION_RAM;
  assign bus.mapper_wr   = bus.mem_wr && i_cpu_address[15:2] == 14'h3FFF;
  assign bus.mapper_idx  = i_cpu_address[1:0];

  assign bus.address  = i_cpu_address;
  assign bus.data_out = i_cpu_data_out;

  // A read and a write port never decode together
  a_one_io_sel: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    !(bus.io_rd_sel != sms_bus_pkg::IO_NONE && bus.io_wr_sel != sms_bus_pkg::IO_NONE));

endmodule

/* sms_mapper.sv */
`include "sms_glue_config.svh"

module sms_mapper (
  input  logic                   cpuClock,
  input  logic                   n_hard_reset,
  sms_cpu_bus_if.periph          bus,
  input  sms_bus_pkg::cpu_byte_t i_io_data,
  output sms_bus_pkg::rom_addr_t o_rom_addr,
  output logic                   o_bios_sel
);

  logic [`SMS_SLOT_W-1:0]   slot0, slot1, slot2;
  sms_bus_pkg::cpu_byte_t   mem_ctrl;
  sms_bus_pkg::mem_region_t region;
  logic [`SMS_BANK_AW-1:0]  offset;

  // ======================================================================
  // Slot and memory-control registers
  // ======================================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      slot0    <= `SMS_SLOT0_RST;
      slot1    <= `SMS_SLOT1_RST;
      slot2    <= `SMS_SLOT2_RST;
      mem_ctrl <= `SMS_MEM_CTRL_RST;
    end else if (bus.cpu_edge) begin
      if (bus.io_wr_sel == sms_bus_pkg::IO_MEM_CTRL)
        mem_ctrl <= i_io_data;
      if (bus.mapper_wr) begin
        case (bus.mapper_idx)
          2'd1:    slot0 <= i_io_data;  // FFFD
          2'd2:    slot1 <= i_io_data;  // FFFE
          2'd3:    slot2 <= i_io_data;  // FFFF
          default: ;                    // FFFC has no register here
        endcase
      end
    end
  end

  // ======================================================================
  // Cartridge address
  // ======================================================================
  assign region = sms_bus_pkg::mem_region_t'(bus.address[15:14]);
  assign offset = bus.address[`SMS_BANK_AW-1:0];

  always_comb begin
    case (region)
      sms_bus_pkg::REGION_SLOT0: o_rom_addr = {slot0, offset};
      sms_bus_pkg::REGION_SLOT1: o_rom_addr = {slot1, offset};
      sms_bus_pkg::REGION_SLOT2: o_rom_addr = {slot2, offset};
      default: o_rom_addr = sms_bus_pkg::rom_addr_t'(bus.address);  // Unmapped
    endcase
  end

  assign o_bios_sel = !mem_ctrl[3];

  // The mapper lives in memory space, so an I/O cycle must never hit it
  a_mapper_not_io: assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    !(bus.mapper_wr && bus.io_wr_sel != sms_bus_pkg::IO_NONE));

endmodule

/* sms_vdp_port.sv */
`include "sms_glue_config.svh"

module sms_vdp_port (
  input  logic                     cpuClock,
  input  logic                     n_hard_reset,
  sms_cpu_bus_if.periph            bus,
  output logic [`SMS_VRAM_AW-1:0]  o_vram_addr,
  output logic                     o_vdp_wr,
  output logic                     o_vdp_rd,
  output logic                     o_cram_sel,
  output sms_vdp_pkg::vdp_mode_t   o_mode,
  output logic                     o_video_on,
  output logic [`SMS_VRAM_AW-1:0]  o_name_table_addr
);

  logic                        data_rd, data_wr, ctrl_rd, ctrl_wr;
  logic                        data_rd_q;
  logic                        second_byte;  // Next control write completes the pair
  sms_bus_pkg::cpu_byte_t      first_byte;
  sms_vdp_pkg::vdp_ctrl_byte_u ctrl_byte;
  sms_vdp_pkg::vdp_reg_idx_t   reg_idx;
  logic                        reg_we;
  logic                        m1, m2, m3, m4;
  sms_bus_pkg::cpu_byte_t      regs [`SMS_VDP_REGS];

  assign data_rd   = bus.io_rd_sel == sms_bus_pkg::IO_VDP_DATA;
  assign data_wr   = bus.io_wr_sel == sms_bus_pkg::IO_VDP_DATA;
  assign ctrl_rd   = bus.io_rd_sel == sms_bus_pkg::IO_VDP_CTRL;
  assign ctrl_wr   = bus.io_wr_sel == sms_bus_pkg::IO_VDP_CTRL;
  assign ctrl_byte = sms_vdp_pkg::vdp_ctrl_byte_u'(bus.data_out);
  assign reg_idx   = ctrl_byte.reg_wr.idx;

  assign reg_we = bus.cpu_edge && ctrl_wr && second_byte &&
                  ctrl_byte.reg_wr.code == sms_vdp_pkg::CODE_REG_WR &&
                  reg_idx < `SMS_VDP_REGS;

  assign o_vdp_wr = data_wr && bus.cpu_edge;
  assign o_vdp_rd = data_rd && bus.cpu_edge;

  // ======================================================================
  // Control-port sequencer
  // ======================================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      second_byte <= 1'b0;
      data_rd_q   <= 1'b0;
      o_cram_sel  <= 1'b0;
      o_vram_addr <= '0;
      for (int i = 0; i < `SMS_VDP_REGS; i++)
        regs[i] <= '0;
    end else if (bus.cpu_edge) begin
      data_rd_q <= data_rd;
      // Post-increment after a write, or once a read has ended
      if (data_wr || (data_rd_q && !data_rd))
        o_vram_addr <= o_vram_addr + 1'b1;
      if (ctrl_rd || data_rd || data_wr)
        second_byte <= 1'b0;
      if (ctrl_wr) begin
        second_byte <= !second_byte;
        if (!second_byte) begin
          first_byte <= bus.data_out;
        end else begin
          case (ctrl_byte.addr.code)
            sms_vdp_pkg::CODE_VRAM_RD, sms_vdp_pkg::CODE_VRAM_WR: begin
              o_vram_addr <= {ctrl_byte.addr.addr_hi, first_byte};
              o_cram_sel  <= 1'b0;
            end
            sms_vdp_pkg::CODE_REG_WR: begin
              if (reg_we) begin
                regs[reg_idx] <= first_byte;
              end else begin  // Out-of-range index acts as CRAM
                o_vram_addr <= `SMS_VRAM_AW'(first_byte[5:0]);
                o_cram_sel  <= 1'b1;
              end
            end
            default: begin
              o_vram_addr <= `SMS_VRAM_AW'(first_byte[5:0]);
              o_cram_sel  <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  // ======================================================================
  // Register decode
  // ======================================================================
  assign m1 = regs[1][4];
  assign m2 = regs[0][1];
  assign m3 = regs[1][3];
  assign m4 = regs[0][2];

  assign o_mode = m4 ? sms_vdp_pkg::MODE_4 :
                  m3 ? sms_vdp_pkg::MODE_3 :
                  m2 ? sms_vdp_pkg::MODE_2 :
                  m1 ? sms_vdp_pkg::MODE_1 : sms_vdp_pkg::MODE_0;

  assign o_name_table_addr = {regs[2][3:1], 11'b0};
  assign o_video_on        = regs[1][6];

endmodule

/* sms_read_mux.sv */
`include "sms_glue_config.svh"

module sms_read_mux (
  input  logic                   cpuClock,
  input  logic                   n_hard_reset,
  sms_cpu_bus_if.periph          bus,
  input  logic                   i_bios_sel,
  input  sms_bus_pkg::cpu_byte_t i_ram_data,
  input  sms_bus_pkg::cpu_byte_t i_bios_data,
  input  sms_bus_pkg::cpu_byte_t i_rom_data,
  input  sms_bus_pkg::cpu_byte_t i_vram_data,
  input  sms_bus_pkg::cpu_byte_t i_v_counter,
  input  sms_bus_pkg::cpu_byte_t i_h_counter,
  input  logic                   i_interrupt_flag,
  input  logic                   i_sprite_collision,
  input  logic                   i_too_many_sprites,
  input  logic [4:0]             i_spritex,
  input  logic [`SMS_BTN_W-1:0]  i_btn,
  output sms_bus_pkg::cpu_byte_t o_cpu_data_in
);

  logic                   int_flag_q, collision_q;
  logic                   status_rd, status_rd_q;
  logic [`SMS_BTN_W-1:0]  btn_q;
  sms_bus_pkg::cpu_byte_t status, joy0;

  // ======================================================================
  // Status flag latches
  // ======================================================================
  assign status_rd = bus.io_rd_sel == sms_bus_pkg::IO_VDP_CTRL;

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      int_flag_q  <= 1'b0;
      collision_q <= 1'b0;
      status_rd_q <= 1'b0;
    end else begin
      if (i_interrupt_flag) int_flag_q <= 1'b1;
      if (i_sprite_collision) collision_q <= 1'b1;
      if (bus.cpu_edge) begin
        status_rd_q <= status_rd;
        if (status_rd_q && !status_rd) begin  // Status read just ended
          int_flag_q  <= 1'b0;
          collision_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge cpuClock)
    btn_q <= i_btn;

  assign status = {int_flag_q, i_too_many_sprites, collision_q,
                   i_too_many_sprites ? i_spritex : 5'b11111};
  assign joy0   = {2'b11, ~btn_q[2:1], ~btn_q[6:3]};  // Active-low pad

  // ======================================================================
  // CPU read data
  // ======================================================================
  always_comb begin
    case (bus.io_rd_sel)
      sms_bus_pkg::IO_VDP_DATA: o_cpu_data_in = i_vram_data;
      sms_bus_pkg::IO_VDP_CTRL: o_cpu_data_in = status;
      sms_bus_pkg::IO_JOY0:     o_cpu_data_in = joy0;
      sms_bus_pkg::IO_JOY1:     o_cpu_data_in = 8'hBF;
      sms_bus_pkg::IO_VCOUNT:   o_cpu_data_in = i_v_counter;
      sms_bus_pkg::IO_HCOUNT:   o_cpu_data_in = i_h_counter;
      default: begin
        if (bus.mem_rd_cart)
          o_cpu_data_in = i_bios_sel ? i_bios_data : i_rom_data;
        else
          o_cpu_data_in = i_ram_data;
      end
    endcase
  end

endmodule

/* sms_glue.sv */
`include "sms_glue_config.svh"

module sms_glue (
  input  logic                    cpuClock,
  input  logic                    n_hard_reset,
  // Z80 bus
  input  sms_bus_pkg::cpu_addr_t  i_cpu_address,
  input  sms_bus_pkg::cpu_byte_t  i_cpu_data_out,
  input  logic                    i_n_rd,
  input  logic                    i_n_wr,
  input  logic                    i_n_mreq,
  input  logic                    i_n_iorq,
  output logic                    o_cpu_clk_en,
  output sms_bus_pkg::cpu_byte_t  o_cpu_data_in,
  // Memories
  input  sms_bus_pkg::cpu_byte_t  i_ram_data,
  input  sms_bus_pkg::cpu_byte_t  i_bios_data,
  input  sms_bus_pkg::cpu_byte_t  i_rom_data,
  output logic                    o_ram_we,
  output sms_bus_pkg::rom_addr_t  o_rom_addr,
  output logic                    o_bios_sel,
  // Video chip
  input  sms_bus_pkg::cpu_byte_t  i_vram_data,
  input  sms_bus_pkg::cpu_byte_t  i_v_counter,
  input  sms_bus_pkg::cpu_byte_t  i_h_counter,
  input  logic                    i_interrupt_flag,
  input  logic                    i_sprite_collision,
  input  logic                    i_too_many_sprites,
  input  logic [4:0]              i_spritex,
  output logic [`SMS_VRAM_AW-1:0] o_vram_addr,
  output logic                    o_vdp_wr,
  output logic                    o_vdp_rd,
  output logic                    o_cram_sel,
  output sms_vdp_pkg::vdp_mode_t  o_mode,
  output logic                    o_video_on,
  output logic [`SMS_VRAM_AW-1:0] o_name_table_addr,
  // Pad
  input  logic [`SMS_BTN_W-1:0]   i_btn
);

  sms_cpu_bus_if bus_if ();

  sms_bus_ctrl bus_ctrl_i (
    .cpuClock       (cpuClock),
    .n_hard_reset   (n_hard_reset),
    .i_cpu_address  (i_cpu_address),
    .i_cpu_data_out (i_cpu_data_out),
    .i_n_rd         (i_n_rd),
    .i_n_wr         (i_n_wr),
    .i_n_mreq       (i_n_mreq),
    .i_n_iorq       (i_n_iorq),
    .o_cpu_clk_en   (o_cpu_clk_en),
    .o_ram_we       (o_ram_we),
    .bus            (bus_if.ctrl)
  );

  sms_mapper mapper_i (
    .cpuClock     (cpuClock),
    .n_hard_reset (n_hard_reset),
    .bus          (bus_if.periph),
    .i_io_data    (i_cpu_data_out),
    .o_rom_addr   (o_rom_addr),
    .o_bios_sel   (o_bios_sel)
  );

  sms_vdp_port vdp_port_i (
    .cpuClock          (cpuClock),
    .n_hard_reset      (n_hard_reset),
    .bus               (bus_if.periph),
    .o_vram_addr       (o_vram_addr),
    .o_vdp_wr          (o_vdp_wr),
    .o_vdp_rd          (o_vdp_rd),
    .o_cram_sel        (o_cram_sel),
    .o_mode            (o_mode),
    .o_video_on        (o_video_on),
    .o_name_table_addr (o_name_table_addr)
  );

  sms_read_mux read_mux_i (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .bus                (bus_if.periph),
    .i_bios_sel         (o_bios_sel),  // From the memory-control register
    .i_ram_data         (i_ram_data),
    .i_bios_data        (i_bios_data),
    .i_rom_data         (i_rom_data),
    .i_vram_data        (i_vram_data),
    .i_v_counter        (i_v_counter),
    .i_h_counter        (i_h_counter),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_spritex          (i_spritex),
    .i_btn              (i_btn),
    .o_cpu_data_in      (o_cpu_data_in)
  );

endmodule

/* tb_sms_glue.sv */
`include "sms_glue_config.svh"

module tb_sms_glue;

  localparam int ROWS      = 44;
  localparam int EN_PERIOD = 70;  // 7 cpuClock cycles
  localparam int EN_HIGH   = 30;  // 3 cpuClock cycles

  // Fixed memory and video patterns
  localparam logic [7:0] RAM_PAT  = 8'h5A;
  localparam logic [7:0] BIOS_PAT = 8'hB1;
  localparam logic [7:0] ROM_PAT  = 8'hC3;
  localparam logic [7:0] VRAM_PAT = 8'h7E;
  localparam logic [7:0] VCNT_PAT = 8'h42;
  localparam logic [7:0] HCNT_PAT = 8'h99;

  typedef enum {OP_IDLE, OP_IOW, OP_IOR, OP_MEMW, OP_MEMR, OP_FLAGS} op_t;

  typedef enum {
    CHK_NONE, CHK_DATA, CHK_ROM_ADDR, CHK_RAM_WE, CHK_VRAM_ADDR, CHK_VDP_WR,
    CHK_VDP_RD, CHK_CRAM_SEL, CHK_MODE, CHK_VIDEO_ON, CHK_NAME_TBL, CHK_JOY0,
    CHK_BIOS_SEL
  } chk_t;

  typedef struct {
    op_t         op;
    logic [15:0] addr;
    logic [7:0]  data;   // FLAGS rows use {too_many, int, collision, spritex}
    chk_t        chk;
    logic [31:0] exp;
  } row_t;

  logic                    cpuClock;
  logic                    n_hard_reset;
  logic [15:0]             i_cpu_address;
  logic [7:0]              i_cpu_data_out;
  logic                    i_n_rd, i_n_wr, i_n_mreq, i_n_iorq;
  logic [7:0]              i_ram_data, i_bios_data, i_rom_data;
  logic [7:0]              i_vram_data, i_v_counter, i_h_counter;
  logic                    i_interrupt_flag, i_sprite_collision, i_too_many_sprites;
  logic [4:0]              i_spritex;
  logic [`SMS_BTN_W-1:0]   i_btn;
  logic                    o_cpu_clk_en;
  logic [7:0]              o_cpu_data_in;
  logic                    o_ram_we, o_bios_sel;
  logic [21:0]             o_rom_addr;
  logic [`SMS_VRAM_AW-1:0] o_vram_addr, o_name_table_addr;
  logic                    o_vdp_wr, o_vdp_rd, o_cram_sel, o_video_on;
  sms_vdp_pkg::vdp_mode_t  o_mode;

  row_t        tbl [ROWS];
  int          n_rows;
  logic [31:0] lcg_state;
  time         last_rise;
  logic        seen_rise = 1'b0;

  sms_glue sms_glue_i (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .i_cpu_address      (i_cpu_address),
    .i_cpu_data_out     (i_cpu_data_out),
    .i_n_rd             (i_n_rd),
    .i_n_wr             (i_n_wr),
    .i_n_mreq           (i_n_mreq),
    .i_n_iorq           (i_n_iorq),
    .o_cpu_clk_en       (o_cpu_clk_en),
    .o_cpu_data_in      (o_cpu_data_in),
    .i_ram_data         (i_ram_data),
    .i_bios_data        (i_bios_data),
    .i_rom_data         (i_rom_data),
    .o_ram_we           (o_ram_we),
    .o_rom_addr         (o_rom_addr),
    .o_bios_sel         (o_bios_sel),
    .i_vram_data        (i_vram_data),
    .i_v_counter        (i_v_counter),
    .i_h_counter        (i_h_counter),
    .i_interrupt_flag   (i_interrupt_flag),
    .i_sprite_collision (i_sprite_collision),
    .i_too_many_sprites (i_too_many_sprites),
    .i_spritex          (i_spritex),
    .o_vram_addr        (o_vram_addr),
    .o_vdp_wr           (o_vdp_wr),
    .o_vdp_rd           (o_vdp_rd),
    .o_cram_sel         (o_cram_sel),
    .o_mode             (o_mode),
    .o_video_on         (o_video_on),
    .o_name_table_addr  (o_name_table_addr),
    .i_btn              (i_btn)
  );

  always #5 cpuClock = ~cpuClock;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Active-low pad byte as the CPU sees it on joy0
  function automatic logic [7:0] pad_byte(input logic [6:0] b);
    return {2'b11, ~b[2:1], ~b[6:3]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("STATUS: FAIL");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // ====================================================================
  // Stimulus table
  // ====================================================================
  task automatic add_row(input op_t op, input logic [15:0] addr, input logic [7:0] data,
                         input chk_t chk, input logic [31:0] exp);
    tbl[n_rows] = '{op, addr, data, chk, exp};
    n_rows++;
  endtask

  task automatic load_table();
    n_rows = 0;
    add_row(OP_MEMR,  16'h0123, 8'h00, CHK_DATA,     32'(BIOS_PAT));  // BIOS after reset
    add_row(OP_MEMR,  16'h4567, 8'h00, CHK_ROM_ADDR, 32'h004567);
    add_row(OP_MEMW,  16'hFFFD, 8'h05, CHK_RAM_WE,   32'd1);
    add_row(OP_MEMW,  16'hFFFE, 8'h0A, CHK_NONE,     32'd0);
    add_row(OP_MEMW,  16'hFFFF, 8'h13, CHK_NONE,     32'd0);
    add_row(OP_MEMR,  16'h1234, 8'h00, CHK_ROM_ADDR, 32'h015234);
    add_row(OP_MEMR,  16'h6ABC, 8'h00, CHK_ROM_ADDR, 32'h02AABC);
    add_row(OP_MEMR,  16'hBFFF, 8'h00, CHK_ROM_ADDR, 32'h04FFFF);
    add_row(OP_MEMR,  16'hD000, 8'h00, CHK_DATA,     32'(RAM_PAT));
    add_row(OP_IOW,   16'h003E, 8'h08, CHK_BIOS_SEL, 32'd0);          // Cartridge on
    add_row(OP_MEMR,  16'h0100, 8'h00, CHK_DATA,     32'(ROM_PAT));
    add_row(OP_MEMW,  16'h2000, 8'h00, CHK_RAM_WE,   32'd0);
    // Register writes, first byte then code 2 and index
    add_row(OP_IOW,   16'h00BF, 8'h10, CHK_NONE,     32'd0);
    add_row(OP_IOW,   16'h00BF, 8'h81, CHK_MODE,     32'(sms_vdp_pkg::MODE_1));
    add_row(OP_IOW,   16'h00BF, 8'h58, CHK_NONE,     32'd0);
    add_row(OP_IOW,   16'h00BF, 8'h81, CHK_VIDEO_ON, 32'd1);
    add_row(OP_IDLE,  16'h0000, 8'h00, CHK_MODE,     32'(sms_vdp_pkg::MODE_3));
    add_row(OP_IOW,   16'h00BF, 8'h04, CHK_NONE,     32'd0);
    add_row(OP_IOW,   16'h00BF, 8'h80, CHK_MODE,     32'(sms_vdp_pkg::MODE_4));
    add_row(OP_IOW,   16'h00BF, 8'h0E, CHK_NONE,     32'd0);
    add_row(OP_IOW,   16'h00BF, 8'h82, CHK_NAME_TBL, 32'h3800);
    add_row(OP_IOW,   16'h00BF, 8'h15, CHK_NONE,     32'd0);
    add_row(OP_IOW,   16'h00BF, 8'h8B, CHK_CRAM_SEL, 32'd1);          // Index 11
    // VRAM addressing
    add_row(OP_IOW,   16'h00BF, 8'h34, CHK_NONE,     32'd0);
    add_row(OP_IOW,   16'h00BF, 8'h52, CHK_VRAM_ADDR, 32'h1234);
    add_row(OP_IOW,   16'h00BE, 8'hAA, CHK_CRAM_SEL, 32'd0);
    add_row(OP_IOW,   16'h00BE, 8'hBB, CHK_VDP_WR,   32'd1);
    add_row(OP_IDLE,  16'h0000, 8'h00, CHK_VRAM_ADDR, 32'h1236);
    add_row(OP_IOR,   16'h00BE, 8'h00, CHK_VDP_RD,   32'd1);
    add_row(OP_IOR,   16'h00BE, 8'h00, CHK_DATA,     32'(VRAM_PAT));
    add_row(OP_IOR,   16'h00BE, 8'h00, CHK_VRAM_ADDR, 32'h1236);     // Held while reading
    add_row(OP_IDLE,  16'h0000, 8'h00, CHK_VRAM_ADDR, 32'h1237);
    add_row(OP_IOW,   16'h00BF, 8'h00, CHK_NONE,     32'd0);
    add_row(OP_IOW,   16'h00BF, 8'hC0, CHK_CRAM_SEL, 32'd1);          // Code 3
    // Status flags
    add_row(OP_FLAGS, 16'h0000, 8'hEA, CHK_NONE,     32'd0);
    add_row(OP_IOR,   16'h00BF, 8'h00, CHK_DATA,     32'hEA);
    add_row(OP_FLAGS, 16'h0000, 8'h05, CHK_NONE,     32'd0);          // No pulses
    add_row(OP_IOR,   16'h00BF, 8'h00, CHK_DATA,     32'h1F);
    add_row(OP_FLAGS, 16'h0000, 8'h60, CHK_NONE,     32'd0);
    add_row(OP_IOR,   16'h00BF, 8'h00, CHK_DATA,     32'hBF);
    // Pad and counters
    add_row(OP_IOR,   16'h00DC, 8'h00, CHK_JOY0,     32'd0);
    add_row(OP_IOR,   16'h00DD, 8'h00, CHK_DATA,     32'hBF);
    add_row(OP_IOR,   16'h007E, 8'h00, CHK_DATA,     32'(VCNT_PAT));
    add_row(OP_IOR,   16'h007F, 8'h00, CHK_DATA,     32'(HCNT_PAT));
  endtask

  task automatic apply_row(input int i);
    i_n_rd         = 1'b1;
    i_n_wr         = 1'b1;
    i_n_mreq       = 1'b1;
    i_n_iorq       = 1'b1;
    i_cpu_address  = tbl[i].addr;
    i_cpu_data_out = tbl[i].data;
    lcg_state      = lcg_next(lcg_state);
    i_btn          = lcg_state[22:16];
    case (tbl[i].op)
      OP_IOW: begin
        i_n_iorq = 1'b0;
        i_n_wr   = 1'b0;
      end
      OP_IOR: begin
        i_n_iorq = 1'b0;
        i_n_rd   = 1'b0;
      end
      OP_MEMW: begin
        i_n_mreq = 1'b0;
        i_n_wr   = 1'b0;
      end
      OP_MEMR: begin
        i_n_mreq = 1'b0;
        i_n_rd   = 1'b0;
      end
      OP_FLAGS: begin  // Levels now, pulses later in the period
        i_too_many_sprites = tbl[i].data[7];
        i_spritex          = tbl[i].data[4:0];
      end
      default: ;
    endcase
  endtask

  // ====================================================================
  // Checks
  // ====================================================================
  task automatic check_row(input int i);
    string tag;
    tag = $sformatf("row %0d", i);
    case (tbl[i].chk)
      CHK_DATA:      check_value({tag, " cpu data"}, 32'(o_cpu_data_in), tbl[i].exp);
      CHK_ROM_ADDR:  check_value({tag, " rom addr"}, 32'(o_rom_addr), tbl[i].exp);
      CHK_RAM_WE:    check_value({tag, " ram we"}, 32'(o_ram_we), tbl[i].exp);
      CHK_VRAM_ADDR: check_value({tag, " vram addr"}, 32'(o_vram_addr), tbl[i].exp);
      CHK_VDP_WR:    check_value({tag, " vdp wr"}, 32'(o_vdp_wr), tbl[i].exp);
      CHK_VDP_RD:    check_value({tag, " vdp rd"}, 32'(o_vdp_rd), tbl[i].exp);
      CHK_CRAM_SEL:  check_value({tag, " cram sel"}, 32'(o_cram_sel), tbl[i].exp);
      CHK_MODE:      check_value({tag, " mode"}, 32'(o_mode), tbl[i].exp);
      CHK_VIDEO_ON:  check_value({tag, " video on"}, 32'(o_video_on), tbl[i].exp);
      CHK_NAME_TBL:  check_value({tag, " name table"}, 32'(o_name_table_addr), tbl[i].exp);
      CHK_JOY0:      check_value({tag, " joy0"}, 32'(o_cpu_data_in), 32'(pad_byte(i_btn)));
      CHK_BIOS_SEL:  check_value({tag, " bios sel"}, 32'(o_bios_sel), tbl[i].exp);
      default: ;
    endcase
  endtask

  // Enable period and high time, over the whole run
  always @(posedge o_cpu_clk_en) begin
    if (seen_rise)
      check_value("enable period", 32'($time - last_rise), 32'(EN_PERIOD));
    if (n_hard_reset === 1'b1)
      seen_rise = 1'b1;
    last_rise = $time;
  end

  always @(negedge o_cpu_clk_en) begin
    if (seen_rise)
      check_value("enable high time", 32'($time - last_rise), 32'(EN_HIGH));
  end

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    #(ROWS * EN_PERIOD + 200);
    $display("TIMEOUT: the row loop did not finish within %0d time units",
             ROWS * EN_PERIOD + 200);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    cpuClock           = 1'b0;
    n_hard_reset       = 1'b0;
    i_cpu_address      = '0;
    i_cpu_data_out     = '0;
    i_n_rd             = 1'b1;
    i_n_wr             = 1'b1;
    i_n_mreq           = 1'b1;
    i_n_iorq           = 1'b1;
    i_ram_data         = RAM_PAT;
    i_bios_data        = BIOS_PAT;
    i_rom_data         = ROM_PAT;
    i_vram_data        = VRAM_PAT;
    i_v_counter        = VCNT_PAT;
    i_h_counter        = HCNT_PAT;
    i_interrupt_flag   = 1'b0;
    i_sprite_collision = 1'b0;
    i_too_many_sprites = 1'b0;
    i_spritex          = '0;
    i_btn              = '0;
    lcg_state          = 32'd44;
    load_table();
    if (n_rows != ROWS) begin
      $display("The stimulus table holds %0d rows instead of %0d", n_rows, ROWS);
      $display("STATUS: FAIL");
      $fatal(1, "bad table size");
    end
    repeat (10) @(posedge cpuClock);
    @(negedge cpuClock);
    n_hard_reset = 1'b1;
    @(posedge o_cpu_clk_en);
    @(negedge cpuClock);
    // Each row spans one enable period, checked in the next edge cycle
    for (int i = 0; i < ROWS; i++) begin
      apply_row(i);
      if (tbl[i].op == OP_FLAGS) begin  // Clear of an ended read comes first
        repeat (2) @(negedge cpuClock);
        i_interrupt_flag   = tbl[i].data[6];
        i_sprite_collision = tbl[i].data[5];
        @(negedge cpuClock);
        i_interrupt_flag   = 1'b0;
        i_sprite_collision = 1'b0;
      end
      @(posedge o_cpu_clk_en);
      @(negedge cpuClock);
      check_row(i);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* sms_glue.f */
+incdir+.
sms_bus_pkg.sv
sms_vdp_pkg.sv
sms_cpu_bus_if.sv
sms_bus_ctrl.sv
sms_mapper.sv
sms_vdp_port.sv
sms_read_mux.sv
sms_glue.sv
tb_sms_glue.sv

/* Bender.yml */
package:
  name: sms_glue

export_include_dirs:
  - .

sources:
  - sms_bus_pkg.sv
  - sms_vdp_pkg.sv
  - sms_cpu_bus_if.sv
  - sms_bus_ctrl.sv
  - sms_mapper.sv
  - sms_vdp_port.sv
  - sms_read_mux.sv
  - sms_glue.sv
  - target: test
    files:
      - tb_sms_glue.sv
